// File: verilog/muldiv_defs.svh
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// operand and result width of the integer datapath
`define XLEN 32

// restoring divider produces one quotient bit per step
`define DIV_STEPS 32

`endif

// File: verilog/muldiv_pkg.sv
`default_nettype none

`include "muldiv_defs.svh"

package muldiv_pkg;

  // encoding follows funct3 of the M extension
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } alu_op_t;

  // request into the unit
  typedef struct packed {
    alu_op_t          op;
    logic [`XLEN-1:0] rs1;
    logic [`XLEN-1:0] rs2;
    logic [3:0]       tag;
  } muldiv_req_t;

  // response out of the unit, tag echoed from the request
  typedef struct packed {
    logic [`XLEN-1:0] result;
    logic [3:0]       tag;
  } muldiv_rsp_t;

endpackage

`default_nettype wire

// File: verilog/dsp_div.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defs.svh"

module dsp_div (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  muldiv_pkg::alu_op_t  op,
  input  logic [`XLEN-1:0]     left_operand,
  input  logic [`XLEN-1:0]     right_operand,
  output logic                 busy,
  output logic                 done,
  output logic [`XLEN-1:0]     result
);

  localparam int CNT_W = $clog2(`DIV_STEPS);

  // control state
  logic             run;
  logic [CNT_W-1:0] cnt;
  logic             load;
  logic             last_step;

  // iteration registers
  logic [`XLEN:0]   acc;
  logic [`XLEN-1:0] quo;
  logic [`XLEN-1:0] divisor;
  logic             neg_quo;
  logic             neg_rem;
  logic             want_rem;

  // entry side
  logic             is_signed;
  logic             neg_left;
  logic             neg_right;
  logic             div_by_zero;
  logic [`XLEN-1:0] left_mag;
  logic [`XLEN-1:0] right_mag;

  // one step of the loop
  logic [`XLEN:0]   acc_shift;
  logic [`XLEN:0]   acc_next;
  logic [`XLEN-1:0] quo_next;

  // exit side
  logic [`XLEN-1:0] quo_final;
  logic [`XLEN-1:0] rem_final;

  assign load      = start && !busy;
  assign last_step = run && (cnt == CNT_W'(`DIV_STEPS - 1));
  assign busy      = run | done;

  // only signed ops look at the sign bits
  always_comb begin
    is_signed   = (op == muldiv_pkg::DIV) || (op == muldiv_pkg::REM);
    neg_left    = is_signed & left_operand[`XLEN-1];
    neg_right   = is_signed & right_operand[`XLEN-1];
    div_by_zero = (right_operand == '0);
    left_mag    = neg_left ? -left_operand : left_operand;
    right_mag   = neg_right ? -right_operand : right_operand;
  end

  // restoring shift-subtract on magnitudes
  always_comb begin
    acc_shift = {acc[`XLEN-1:0], quo[`XLEN-1]};
    if (acc_shift >= {1'b0, divisor}) begin
      acc_next = acc_shift - {1'b0, divisor};
      quo_next = {quo[`XLEN-2:0], 1'b1};
    end else begin
      acc_next = acc_shift;
      quo_next = {quo[`XLEN-2:0], 1'b0};
    end
  end

  // sign fixup on the way out
  //
  // most negative / -1 has magnitude 2^(XLEN-1) / 1, which reads back as
  // the most negative value again with no negation and a zero remainder.
  // x / 0 never restores, so the quotient is all ones and the remainder
  // is |x|. negating that remainder by the dividend sign gives x back.
  // the all-ones quotient must keep its value, so the quotient flip is
  // suppressed for a zero divisor when the sign flags are captured
  always_comb begin
    quo_final = neg_quo ? -quo_next : quo_next;
    rem_final = neg_rem ? -acc_next[`XLEN-1:0] : acc_next[`XLEN-1:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      run  <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (load) begin
        run <= 1'b1;
        cnt <= '0;
      end else if (run) begin
        cnt <= cnt + 1'b1;
        if (last_step) begin
          run  <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      acc      <= '0;
      quo      <= left_mag;
      divisor  <= right_mag;
      neg_quo  <= (neg_left ^ neg_right) & ~div_by_zero;
      neg_rem  <= neg_left;
      want_rem <= (op == muldiv_pkg::REM) || (op == muldiv_pkg::REMU);
    end else if (run) begin
      acc <= acc_next;
      quo <= quo_next;
      // result lands together with done
      if (last_step) begin
        result <= want_rem ? rem_final : quo_final;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/dsp_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defs.svh"

module dsp_mul (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  muldiv_pkg::alu_op_t  op,
  input  logic [3:0]           tag_in,
  input  logic [`XLEN-1:0]     left_operand,
  input  logic [`XLEN-1:0]     right_operand,
  output logic                 done,
  output logic [3:0]           tag_out,
  output logic [`XLEN-1:0]     result
);

  // stage one
  logic                  v1;
  logic                  hi1;
  logic [3:0]            tag1;
  logic signed [`XLEN:0] a1;
  logic signed [`XLEN:0] b1;

  // stage two
  logic                        hi2;
  logic signed [2*`XLEN+1:0]   prod;

  logic left_signed;
  logic right_signed;

  // MUL takes the low word so its extension does not matter
  assign left_signed  = (op == muldiv_pkg::MULH) || (op == muldiv_pkg::MULHSU);
  assign right_signed = (op == muldiv_pkg::MULH);

  always_ff @(posedge clk) begin
    if (rst) begin
      v1   <= 1'b0;
      done <= 1'b0;
    end else begin
      v1   <= start;
      done <= v1;
    end
  end

  always_ff @(posedge clk) begin
    a1   <= {left_signed & left_operand[`XLEN-1], left_operand};
    b1   <= {right_signed & right_operand[`XLEN-1], right_operand};
    hi1  <= (op != muldiv_pkg::MUL);
    tag1 <= tag_in;
  end

  // 33 x 33 signed covers all three sign mixes
  always_ff @(posedge clk) begin
    prod    <= a1 * b1;
    hi2     <= hi1;
    tag_out <= tag1;
  end

  assign result = hi2 ? prod[2*`XLEN-1:`XLEN] : prod[`XLEN-1:0];

endmodule

`default_nettype wire

// File: verilog/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defs.svh"

module muldiv_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  muldiv_pkg::muldiv_req_t  req,
  output logic                     busy,
  output logic                     rsp_valid,
  output muldiv_pkg::muldiv_rsp_t  rsp
);

  logic             accept;
  logic             is_div;
  logic             div_start;
  logic             mul_start;

  logic             div_busy;
  logic             div_done;
  logic [`XLEN-1:0] div_result;
  logic [3:0]       div_tag;

  logic             mul_done;
  logic [3:0]       mul_tag;
  logic [`XLEN-1:0] mul_result;

  // DIV, DIVU, REM and REMU go to the iterative engine
  assign is_div = req.op inside {muldiv_pkg::DIV, muldiv_pkg::DIVU,
                                 muldiv_pkg::REM, muldiv_pkg::REMU};

  // a start during a division is dropped
  assign accept    = start && !busy;
  assign div_start = accept && is_div;
  assign mul_start = accept && !is_div;

  assign busy = div_busy;

  // divider has no tag path of its own
  always_ff @(posedge clk) begin
    if (div_start) begin
      div_tag <= req.tag;
    end
  end

  dsp_div u_div (
    .clk           (clk),
    .rst           (rst),
    .start         (div_start),
    .op            (req.op),
    .left_operand  (req.rs1),
    .right_operand (req.rs2),
    .busy          (div_busy),
    .done          (div_done),
    .result        (div_result)
  );

  dsp_mul u_mul (
    .clk           (clk),
    .rst           (rst),
    .start         (mul_start),
    .op            (req.op),
    .tag_in        (req.tag),
    .left_operand  (req.rs1),
    .right_operand (req.rs2),
    .done          (mul_done),
    .tag_out       (mul_tag),
    .result        (mul_result)
  );

  // engines never finish in the same cycle
  assign rsp_valid = div_done | mul_done;

  always_comb begin
    if (div_done) begin
      rsp.result = div_result;
      rsp.tag    = div_tag;
    end else begin
      rsp.result = mul_result;
      rsp.tag    = mul_tag;
    end
  end

endmodule

`default_nettype wire

// File: dv/muldiv_ref.svh
`ifndef MULDIV_REF_SVH
`define MULDIV_REF_SVH

`include "muldiv_defs.svh"

// expected result of one M-extension operation
// uses double-width arithmetic plus the RISC-V corner rules
function automatic logic [`XLEN-1:0] muldiv_ref(
  input muldiv_pkg::alu_op_t op,
  input logic [`XLEN-1:0]    a,
  input logic [`XLEN-1:0]    b
);
  logic signed [2*`XLEN-1:0] sa;
  logic signed [2*`XLEN-1:0] sb;
  logic signed [2*`XLEN-1:0] ub_s;
  logic [2*`XLEN-1:0]        ua;
  logic [2*`XLEN-1:0]        ub;
  logic signed [2*`XLEN-1:0] ps;
  logic [2*`XLEN-1:0]        pu;
  logic                      overflow;
  logic [`XLEN-1:0]          res;

  sa   = {{`XLEN{a[`XLEN-1]}}, a};
  sb   = {{`XLEN{b[`XLEN-1]}}, b};
  ua   = {{`XLEN{1'b0}}, a};
  ub   = {{`XLEN{1'b0}}, b};
  ub_s = ub;
  // most negative value over minus one
  overflow = (a == {1'b1, {(`XLEN-1){1'b0}}}) && (b == '1);
  res = '0;
  case (op)
    muldiv_pkg::MUL: begin
      ps  = sa * sb;
      res = ps[`XLEN-1:0];
    end
    muldiv_pkg::MULH: begin
      ps  = sa * sb;
      res = ps[2*`XLEN-1:`XLEN];
    end
    muldiv_pkg::MULHSU: begin
      ps  = sa * ub_s;
      res = ps[2*`XLEN-1:`XLEN];
    end
    muldiv_pkg::MULHU: begin
      pu  = ua * ub;
      res = pu[2*`XLEN-1:`XLEN];
    end
    muldiv_pkg::DIV: begin
      if (b == '0) begin
        res = '1;
      end else if (overflow) begin
        res = a;
      end else begin
        ps  = sa / sb;
        res = ps[`XLEN-1:0];
      end
    end
    muldiv_pkg::DIVU: begin
      if (b == '0) begin
        res = '1;
      end else begin
        pu  = ua / ub;
        res = pu[`XLEN-1:0];
      end
    end
    muldiv_pkg::REM: begin
      if (b == '0) begin
        res = a;
      end else if (overflow) begin
        res = '0;
      end else begin
        // truncating division, remainder takes the dividend sign
        ps  = sa % sb;
        res = ps[`XLEN-1:0];
      end
    end
    muldiv_pkg::REMU: begin
      if (b == '0) begin
        res = a;
      end else begin
        pu  = ua % ub;
        res = pu[`XLEN-1:0];
      end
    end
  endcase
  return res;
endfunction

`endif

// File: dv/tb_muldiv.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defs.svh"

module tb_muldiv;

  localparam int TIMEOUT = 100;
  localparam int MUL_LAT = 2;
  localparam int DIV_LAT = `DIV_STEPS + 1;
  localparam logic [`XLEN-1:0] MOST_NEG = {1'b1, {(`XLEN-1){1'b0}}};

  logic                    clk;
  logic                    rst;
  logic                    start;
  muldiv_pkg::muldiv_req_t req;
  logic                    busy;
  logic                    rsp_valid;
  muldiv_pkg::muldiv_rsp_t rsp;

  // accepted requests in issue order, with the edge their response is due on
  muldiv_pkg::muldiv_req_t req_q[$];
  int                      due_q[$];
  string                   name_q[$];
  // rising edges seen so far
  int                      cyc = 0;

  `include "muldiv_ref.svh"

  muldiv_unit UUT (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .req       (req),
    .busy      (busy),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("Verification failed");
    $fatal(1, "stopping at first error");
  endtask

  function automatic logic is_div_op(input muldiv_pkg::alu_op_t op);
    return op inside {muldiv_pkg::DIV, muldiv_pkg::DIVU, muldiv_pkg::REM, muldiv_pkg::REMU};
  endfunction

  // nonzero magnitude below 2^(XLEN-1), negated on request
  function automatic logic [`XLEN-1:0] rand_operand(input logic neg);
    logic [`XLEN-1:0] mag;
    mag = ($urandom() >> (1 + $urandom_range(30, 0))) | 1;
    return neg ? -mag : mag;
  endfunction

  // compare each response with the head of the queue
  always @(posedge clk) begin : compare
    muldiv_pkg::muldiv_req_t exp_req;
    logic [`XLEN-1:0]        exp_result;
    int                      exp_due;
    string                   exp_name;

    cyc <= cyc + 1;
    if (!rst && rsp_valid) begin
      assert (req_q.size() != 0) else begin
        $display("response with tag %h arrived with no request outstanding", rsp.tag);
        stop_on_error();
      end
      if (req_q.size() != 0) begin
        exp_req    = req_q.pop_front();
        exp_due    = due_q.pop_front();
        exp_name   = name_q.pop_front();
        exp_result = muldiv_ref(exp_req.op, exp_req.rs1, exp_req.rs2);
        assert (rsp.result == exp_result) else begin
          $display("error %s: %s %h %h expected %h actual %h", exp_name, exp_req.op.name(),
                   exp_req.rs1, exp_req.rs2, exp_result, rsp.result);
          stop_on_error();
        end
        assert (rsp.tag == exp_req.tag) else begin
          $display("error %s: tag expected %h actual %h", exp_name, exp_req.tag, rsp.tag);
          stop_on_error();
        end
        assert (cyc == exp_due) else begin
          $display("error %s: response edge expected %0d actual %0d", exp_name, exp_due, cyc);
          stop_on_error();
        end
      end
    end
  end

  // called at a falling edge, returns at the next one
  task automatic send_request(input muldiv_pkg::alu_op_t op, input logic [`XLEN-1:0] a,
                              input logic [`XLEN-1:0] b, input logic [3:0] tag,
                              input string name);
    start   = 1'b1;
    req.op  = op;
    req.rs1 = a;
    req.rs2 = b;
    req.tag = tag;
    // only a start seen with busy low is taken
    if (!busy) begin
      req_q.push_back(req);
      due_q.push_back(cyc + (is_div_op(op) ? DIV_LAT : MUL_LAT));
      name_q.push_back(name);
    end
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (req_q.size() != 0 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    assert (req_q.size() == 0) else begin
      $display("timeout: %0d responses still missing after %0d cycles", req_q.size(), cycles);
      stop_on_error();
    end
  endtask

  task automatic wait_busy_low(output int cycles);
    cycles = 0;
    while (busy && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    assert (!busy) else begin
      $display("timeout: busy still high after %0d cycles", cycles);
      stop_on_error();
    end
  endtask

  task automatic run_single(input muldiv_pkg::alu_op_t op, input logic [`XLEN-1:0] a,
                            input logic [`XLEN-1:0] b, input logic [3:0] tag,
                            input string name);
    int busy_cycles;
    send_request(op, a, b, tag, name);
    if (is_div_op(op)) begin
      wait_busy_low(busy_cycles);
      assert (busy_cycles == DIV_LAT) else begin
        $display("error %s: busy cycles expected %0d actual %0d", name, DIV_LAT, busy_cycles);
        stop_on_error();
      end
    end
    wait_drained();
  endtask

  initial begin : stimulus
    muldiv_pkg::alu_op_t op;
    int                  busy_cycles;

    void'($urandom(57));
    rst   = 1'b1;
    start = 1'b0;
    req   = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // idle after reset
    repeat (50) begin
      assert (!busy && !rsp_valid) else begin
        $display("busy or rsp_valid high while idle after reset");
        stop_on_error();
      end
      @(negedge clk);
    end

    // back to back multiplies
    for (int i = 0; i < 40; i++) begin
      op = muldiv_pkg::alu_op_t'(3'($urandom_range(3, 0)));
      send_request(op, $urandom(), $urandom(), 4'($urandom_range(15, 0)), "mul_random");
    end
    wait_drained();

    // all sign combinations for each divide op
    for (int i = 0; i < 24; i++) begin
      op = muldiv_pkg::alu_op_t'(3'(4 + i[3:2]));
      run_single(op, rand_operand(i[0]), rand_operand(i[1]), 4'(i), "div_random");
    end

    // zero divisor for all four divide ops
    for (int i = 4; i < 8; i++) begin
      op = muldiv_pkg::alu_op_t'(3'(i));
      run_single(op, 32'h8000_1234, '0, 4'h1, "div_corner");
      run_single(op, $urandom(), '0, 4'h2, "div_corner");
      run_single(op, MOST_NEG, '1, 4'h3, "div_corner");
      run_single(op, '0, '1, 4'h4, "div_corner");
      run_single(op, '1, '1, 4'h5, "div_corner");
      run_single(op, '0, '0, 4'h6, "div_corner");
    end
    run_single(muldiv_pkg::MULH, MOST_NEG, MOST_NEG, 4'h7, "mul_corner");
    run_single(muldiv_pkg::MULHSU, '1, '1, 4'h8, "mul_corner");
    run_single(muldiv_pkg::MULHU, '1, '1, 4'h9, "mul_corner");
    run_single(muldiv_pkg::MUL, '0, '1, 4'hb, "mul_corner");

    // starts while a division runs are dropped
    send_request(muldiv_pkg::DIV, 32'hffff_f000, 32'h0000_0007, 4'ha, "drop_while_busy");
    repeat (3) begin
      assert (busy) else begin
        $display("busy low while a division should be running");
        stop_on_error();
      end
      send_request(muldiv_pkg::MUL, $urandom(), $urandom(), 4'h5, "drop_while_busy");
      send_request(muldiv_pkg::DIVU, $urandom(), 32'h3, 4'h6, "drop_while_busy");
    end
    assert (req_q.size() == 1) else begin
      $display("error drop_while_busy: queue size expected 1 actual %0d", req_q.size());
      stop_on_error();
    end
    // six dropped starts already used part of the busy time
    wait_busy_low(busy_cycles);
    assert (busy_cycles == DIV_LAT - 6) else begin
      $display("error drop_while_busy: busy cycles expected %0d actual %0d",
               DIV_LAT - 6, busy_cycles);
      stop_on_error();
    end
    wait_drained();

    // no stray response or busy level once everything has drained
    repeat (5) @(negedge clk);
    assert (!busy && !rsp_valid) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("busy or rsp_valid high after all responses arrived");
      stop_on_error();
    end
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+verilog
+incdir+dv
verilog/muldiv_pkg.sv
verilog/dsp_div.sv
verilog/dsp_mul.sv
verilog/muldiv_unit.sv
dv/tb_muldiv.sv

// File: Makefile
# Verilator build, run and lint for the multiply/divide unit

VERILATOR  ?= verilator
TOP        ?= tb_muldiv
RTL_TOP    ?= muldiv_unit
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Verification passed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides pass or fail, whatever the exit status of the pipe
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
